// ==== Bender.yml ====
package:
  name: ram_access

sources:
  # rtl, package first
  - logic/gpu_ram_pkg.sv
  - logic/cmd_fifo.sv
  - logic/port_arbiter.sv
  - logic/gpu_ram.sv
  - logic/read_return.sv
  - logic/ram_access_top.sv

  # testbench, top module ram_access_tb
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/ram_access_properties.sv
      - test/ram_access_tb.sv

// ==== filelist.f ====
logic/gpu_ram_pkg.sv
logic/cmd_fifo.sv
logic/port_arbiter.sv
logic/gpu_ram.sv
logic/read_return.sv
logic/ram_access_top.sv
test/tb_clock_gen.sv
test/ram_access_properties.sv
test/ram_access_tb.sv

// ==== logic/cmd_fifo.sv ====
`timescale 1ns/10ps

module cmd_fifo #(
   parameter type payload_t = logic [7:0],
   parameter int  DEPTH     = 3
) (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     push,              // one-cycle load strobe
   input  payload_t push_data,
   input  logic     pop,               // consumer took head this cycle
   output logic     not_empty,
   output logic     full,
   output payload_t head               // oldest entry, valid while not_empty
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   payload_t         mem [DEPTH];      // payload storage
   logic [PTR_W-1:0] wr_ptr;           // next slot to write
   logic [PTR_W-1:0] rd_ptr;           // slot shown on head
   logic [CNT_W-1:0] count;            // entries held
   logic             do_push;
   logic             do_pop;

   assign do_pop    = pop && not_empty;          // ignore pop on an empty buffer
   assign do_push   = push && (!full || do_pop); // full slot frees up on the same edge
   assign not_empty = (count != '0);
   assign full      = (count == CNT_W'(DEPTH));
   assign head      = mem[rd_ptr];

   // payload storage
   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   // pointers and occupancy
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            if (wr_ptr == PTR_W'(DEPTH - 1)) begin
               wr_ptr <= '0;           // wrap
            end else begin
               wr_ptr <= wr_ptr + 1'b1;
            end
         end
         if (do_pop) begin
            if (rd_ptr == PTR_W'(DEPTH - 1)) begin
               rd_ptr <= '0;           // wrap
            end else begin
               rd_ptr <= rd_ptr + 1'b1;
            end
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // idle or push and pop together
         endcase
      end
   end

endmodule

// ==== logic/gpu_ram.sv ====
`timescale 1ns/10ps

module gpu_ram (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  ram_valid,
   input  gpu_ram_pkg::ram_cmd_t ram_cmd,
   output logic [15:0]           rd_word   // valid READ_LATENCY cycles after the command edge
);

   localparam int LAT = gpu_ram_pkg::READ_LATENCY;

   logic [15:0]                       mem [gpu_ram_pkg::RAM_WORDS];
   logic [gpu_ram_pkg::WORD_AW-1:0]   word_idx;       // addr / 2, wraps at 8 KiB
   logic [1:0]                        lane_we;        // [1] high byte, [0] low byte
   logic                              rd_en;
   logic [15:0]                       rd_pipe [LAT];  // read data pipeline

   assign word_idx = ram_cmd.addr[gpu_ram_pkg::WORD_AW:1];
   assign rd_en    = ram_valid && !ram_cmd.wr;

   // lane enables, a byte write touches only the lane picked by addr bit 0
   always_comb begin
      lane_we = 2'b00;
      if (ram_valid && ram_cmd.wr) begin
         if (ram_cmd.wide) begin
            lane_we = 2'b11;
         end else begin
            lane_we = ram_cmd.addr[0] ? 2'b10 : 2'b01;
         end
      end
   end

   // word array
   always_ff @(posedge clk) begin
      if (lane_we[0]) begin
         mem[word_idx][7:0] <= ram_cmd.data[7:0];
      end
      if (lane_we[1]) begin
         mem[word_idx][15:8] <= ram_cmd.data[15:8];
      end
   end

   // read pipeline, first stage samples the array
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < LAT; i++) begin
            rd_pipe[i] <= '0;
         end
      end else begin
         rd_pipe[0] <= rd_en ? mem[word_idx] : '0;   // idle slots carry zero
         for (int i = 1; i < LAT; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
         end
      end
   end

   assign rd_word = rd_pipe[LAT-1];

endmodule

// ==== logic/gpu_ram_pkg.sv ====
package gpu_ram_pkg;

   // address and memory geometry
   localparam int ADDR_W      = 20;    // byte address width on every port
   localparam int RAM_WORDS   = 4096;  // 16-bit words, 8 KiB in total
   localparam int WORD_AW     = $clog2(RAM_WORDS); // word index width, addr bits [12:1]
   localparam int DATA_W      = 16;    // ram word width
   localparam int BYTE_W      = 8;     // byte port data width

   // timing
   localparam int READ_LATENCY = 2;    // cycles from ram command edge to valid data

   // command buffering
   localparam int BYTE_FIFO_DEPTH = 3; // cpu and serial fifo depth
   localparam int GEO_FIFO_DEPTH  = 3; // geometry fifo depth, drives geo_full

   // destination of a read, travels with the command to the return block
   typedef enum logic [2:0] {
      TAG_NONE   = 3'd0,               // write or idle slot
      TAG_CPU    = 3'd1,               // z80 side
      TAG_SERIAL = 3'd2,               // rs232 debug side
      TAG_GEO_A  = 3'd3,               // geometry read channel a
      TAG_GEO_B  = 3'd4                // geometry read channel b
   } rd_tag_t;

   // byte port command, 30 bits
   typedef struct packed {
      logic              rd;           // read strobe
      logic              wr;           // write strobe
      logic [ADDR_W-1:0] addr;         // byte address
      logic [BYTE_W-1:0] data;         // write byte
   } byte_cmd_t;

   // geometry port command, 39 bits
   typedef struct packed {
      logic              rd_a;         // read on channel a
      logic              rd_b;         // read on channel b
      logic              wr;           // 16-bit write
      logic [ADDR_W-1:0] addr;         // byte address, bit 0 ignored by the ram
      logic [DATA_W-1:0] data;         // write word
   } geo_cmd_t;

   // registered command toward the ram
   typedef struct packed {
      logic              wr;           // write when set, read otherwise
      logic              wide;         // 16-bit access from the geometry port
      logic [ADDR_W-1:0] addr;         // byte address
      logic [DATA_W-1:0] data;         // byte copied into both lanes when not wide
      rd_tag_t           tag;          // who gets the read data
   } ram_cmd_t;

   // Addresses above 8 KiB alias back onto the array, the upper address
   // bits are simply not decoded by the ram model.

endpackage

// ==== logic/port_arbiter.sv ====
`timescale 1ns/10ps

module port_arbiter (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  cpu_ready,     // cpu fifo not empty
   input  logic                  serial_ready,  // serial fifo not empty
   input  logic                  geo_ready,     // geometry fifo not empty
   input  gpu_ram_pkg::byte_cmd_t cpu_head,
   input  gpu_ram_pkg::byte_cmd_t serial_head,
   input  gpu_ram_pkg::geo_cmd_t  geo_head,
   output logic                  cpu_pop,
   output logic                  serial_pop,
   output logic                  geo_pop,
   output logic                  ram_valid,     // one-cycle strobe per ram command
   output gpu_ram_pkg::ram_cmd_t ram_cmd
);

   logic                  last_cpu;  // 1 when cpu got the latest byte grant
   gpu_ram_pkg::ram_cmd_t next_cmd;  // winning head in ram format

   // byte ports alternate on a tie, geometry only gets idle cycles
   always_comb begin
      cpu_pop    = cpu_ready && (!serial_ready || !last_cpu);
      serial_pop = serial_ready && (!cpu_ready || last_cpu);
      geo_pop    = geo_ready && !cpu_ready && !serial_ready;
   end

   // convert the winner into a ram command and tag its read
   always_comb begin
      next_cmd = '0;
      if (cpu_pop) begin
         next_cmd.wr   = cpu_head.wr;
         next_cmd.wide = 1'b0;
         next_cmd.addr = cpu_head.addr;
         next_cmd.data = {2{cpu_head.data}};   // byte on both lanes
         next_cmd.tag  = cpu_head.rd ? gpu_ram_pkg::TAG_CPU : gpu_ram_pkg::TAG_NONE;
      end else if (serial_pop) begin
         next_cmd.wr   = serial_head.wr;
         next_cmd.wide = 1'b0;
         next_cmd.addr = serial_head.addr;
         next_cmd.data = {2{serial_head.data}};
         next_cmd.tag  = serial_head.rd ? gpu_ram_pkg::TAG_SERIAL : gpu_ram_pkg::TAG_NONE;
      end else if (geo_pop) begin
         next_cmd.wr   = geo_head.wr;
         next_cmd.wide = 1'b1;                 // full word access
         next_cmd.addr = geo_head.addr;
         next_cmd.data = geo_head.data;
         if (geo_head.rd_a) begin
            next_cmd.tag = gpu_ram_pkg::TAG_GEO_A;
         end else if (geo_head.rd_b) begin
            next_cmd.tag = gpu_ram_pkg::TAG_GEO_B;
         end else begin
            next_cmd.tag = gpu_ram_pkg::TAG_NONE;
         end
      end
   end

   // priority state and command strobe
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         last_cpu  <= 1'b1;            // serial wins the first tie
         ram_valid <= 1'b0;
      end else begin
         if (cpu_pop) begin
            last_cpu <= 1'b1;
         end else if (serial_pop) begin
            last_cpu <= 1'b0;
         end
         ram_valid <= cpu_pop || serial_pop || geo_pop;
      end
   end

   // command payload, qualified by ram_valid downstream
   always_ff @(posedge clk) begin
      ram_cmd <= next_cmd;
   end

endmodule

// ==== logic/ram_access_top.sv ====
`timescale 1ns/10ps

module ram_access_top (
   input  logic                           clk,
   input  logic                           rst_n,
   // cpu port, z80 side
   input  logic                           cpu_rd,
   input  logic                           cpu_wr,
   input  logic [gpu_ram_pkg::ADDR_W-1:0] cpu_addr,
   input  logic [7:0]                     cpu_wdata,
   output logic                           cpu_rdy,
   output logic [7:0]                     cpu_data,
   // serial debug port, rs232 side
   input  logic                           serial_rd,
   input  logic                           serial_wr,
   input  logic [gpu_ram_pkg::ADDR_W-1:0] serial_addr,
   input  logic [7:0]                     serial_wdata,
   output logic                           serial_rdy,
   output logic [7:0]                     serial_data,
   // geometry port
   input  logic                           geo_rd_a,
   input  logic                           geo_rd_b,
   input  logic                           geo_wr,
   input  logic [gpu_ram_pkg::ADDR_W-1:0] geo_addr,
   input  logic [15:0]                    geo_wdata,
   output logic                           geo_rdy_a,
   output logic                           geo_rdy_b,
   output logic [15:0]                    geo_data,
   output logic                           geo_full    // pauses the pixel writer
);

   gpu_ram_pkg::byte_cmd_t cpu_cmd, serial_cmd, cpu_head, serial_head;
   gpu_ram_pkg::geo_cmd_t  geo_cmd, geo_head;
   gpu_ram_pkg::ram_cmd_t  ram_cmd;
   logic                   cpu_ready, serial_ready, geo_ready;
   logic                   cpu_pop, serial_pop, geo_pop;
   logic                   ram_valid;
   logic [15:0]            rd_word;

   // pack strobes into commands
   assign cpu_cmd    = '{rd: cpu_rd, wr: cpu_wr, addr: cpu_addr, data: cpu_wdata};
   assign serial_cmd = '{rd: serial_rd, wr: serial_wr, addr: serial_addr, data: serial_wdata};
   assign geo_cmd    = '{rd_a: geo_rd_a, rd_b: geo_rd_b, wr: geo_wr,
                         addr: geo_addr, data: geo_wdata};

   // byte devices are too slow to overrun their fifos, full left open
   cmd_fifo #(.payload_t(gpu_ram_pkg::byte_cmd_t), .DEPTH(gpu_ram_pkg::BYTE_FIFO_DEPTH))
   cpu_fifo (.clk(clk), .rst_n(rst_n), .push(cpu_rd || cpu_wr), .push_data(cpu_cmd),
             .pop(cpu_pop), .not_empty(cpu_ready), .full(), .head(cpu_head));

   cmd_fifo #(.payload_t(gpu_ram_pkg::byte_cmd_t), .DEPTH(gpu_ram_pkg::BYTE_FIFO_DEPTH))
   serial_fifo (.clk(clk), .rst_n(rst_n), .push(serial_rd || serial_wr),
                .push_data(serial_cmd), .pop(serial_pop), .not_empty(serial_ready),
                .full(), .head(serial_head));

   cmd_fifo #(.payload_t(gpu_ram_pkg::geo_cmd_t), .DEPTH(gpu_ram_pkg::GEO_FIFO_DEPTH))
   geo_fifo (.clk(clk), .rst_n(rst_n), .push(geo_rd_a || geo_rd_b || geo_wr),
             .push_data(geo_cmd), .pop(geo_pop), .not_empty(geo_ready),
             .full(geo_full), .head(geo_head));

   port_arbiter port_arbiter_i (
      .clk(clk), .rst_n(rst_n),
      .cpu_ready(cpu_ready), .serial_ready(serial_ready), .geo_ready(geo_ready),
      .cpu_head(cpu_head), .serial_head(serial_head), .geo_head(geo_head),
      .cpu_pop(cpu_pop), .serial_pop(serial_pop), .geo_pop(geo_pop),
      .ram_valid(ram_valid), .ram_cmd(ram_cmd)
   );

   gpu_ram gpu_ram_i (
      .clk(clk), .rst_n(rst_n), .ram_valid(ram_valid), .ram_cmd(ram_cmd), .rd_word(rd_word)
   );

   read_return read_return_i (
      .clk(clk), .rst_n(rst_n), .ram_valid(ram_valid), .ram_cmd(ram_cmd), .rd_word(rd_word),
      .cpu_rdy(cpu_rdy), .serial_rdy(serial_rdy), .geo_rdy_a(geo_rdy_a),
      .geo_rdy_b(geo_rdy_b), .cpu_data(cpu_data), .serial_data(serial_data),
      .geo_data(geo_data)
   );

endmodule

// ==== logic/read_return.sv ====
`timescale 1ns/10ps

module read_return (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  ram_valid,
   input  gpu_ram_pkg::ram_cmd_t ram_cmd,
   input  logic [15:0]           rd_word,     // ram output, aligned with the last stage
   output logic                  cpu_rdy,
   output logic                  serial_rdy,
   output logic                  geo_rdy_a,
   output logic                  geo_rdy_b,
   output logic [7:0]            cpu_data,
   output logic [7:0]            serial_data,
   output logic [15:0]           geo_data
);

   localparam int LAT = gpu_ram_pkg::READ_LATENCY;

   typedef struct packed {
      gpu_ram_pkg::rd_tag_t tag;      // destination port
      logic                 lane;     // addr bit 0, picks the byte
   } ret_slot_t;

   ret_slot_t ret_pipe [LAT];         // one slot per cycle in flight
   ret_slot_t ret_out;                // slot matching rd_word
   logic [7:0] sel_byte;

   // tag delay line, runs in step with the ram pipeline
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < LAT; i++) begin
            ret_pipe[i] <= '{tag: gpu_ram_pkg::TAG_NONE, lane: 1'b0};
         end
      end else begin
         if (ram_valid && !ram_cmd.wr) begin
            ret_pipe[0] <= '{tag: ram_cmd.tag, lane: ram_cmd.addr[0]};
         end else begin
            ret_pipe[0] <= '{tag: gpu_ram_pkg::TAG_NONE, lane: 1'b0};  // writes and idle
         end
         for (int i = 1; i < LAT; i++) begin
            ret_pipe[i] <= ret_pipe[i-1];
         end
      end
   end

   assign ret_out  = ret_pipe[LAT-1];
   assign sel_byte = ret_out.lane ? rd_word[15:8] : rd_word[7:0];   // odd address is high lane

   // exactly one ready line per tag
   assign cpu_rdy     = (ret_out.tag == gpu_ram_pkg::TAG_CPU);
   assign serial_rdy  = (ret_out.tag == gpu_ram_pkg::TAG_SERIAL);
   assign geo_rdy_a   = (ret_out.tag == gpu_ram_pkg::TAG_GEO_A);
   assign geo_rdy_b   = (ret_out.tag == gpu_ram_pkg::TAG_GEO_B);
   assign cpu_data    = sel_byte;
   assign serial_data = sel_byte;
   assign geo_data    = rd_word;      // full word for the geometry unit

endmodule

// ==== test/ram_access_properties.sv ====
`timescale 1ns/10ps

module ram_access_properties (
   input logic clk,
   input logic rst_n,
   input logic cpu_ready,
   input logic serial_ready,
   input logic cpu_pop,
   input logic serial_pop,
   input logic geo_pop,
   input logic cpu_rdy,
   input logic serial_rdy,
   input logic geo_rdy_a,
   input logic geo_rdy_b
);

   int         assert_errors = 0;     // read back by the testbench
   logic [3:0] rdy_vec;

   assign rdy_vec = {cpu_rdy, serial_rdy, geo_rdy_a, geo_rdy_b};

   // one fifo per cycle at most
   a_one_pop: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0({cpu_pop, serial_pop, geo_pop}))
      else begin
         $error("more than one command fifo popped in one cycle");
         assert_errors++;
      end

   // geometry only gets cycles with both byte fifos empty
   a_geo_last: assert property (@(posedge clk) disable iff (!rst_n)
      geo_pop |-> !cpu_ready && !serial_ready)
      else begin
         $error("geometry fifo popped while a byte fifo was ready");
         assert_errors++;
      end

   a_rdy_excl: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(rdy_vec))
      else begin
         $error("two ready lines high in the same cycle");
         assert_errors++;
      end

   // a ready line never stays up for a second cycle
   a_rdy_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      (rdy_vec != 4'b0000) |=> ((rdy_vec & $past(rdy_vec)) == 4'b0000))
      else begin
         $error("ready pulse longer than one cycle");
         assert_errors++;
      end

endmodule

bind ram_access_top ram_access_properties ram_access_properties_i (
   .clk(clk), .rst_n(rst_n),
   .cpu_ready(cpu_ready), .serial_ready(serial_ready),
   .cpu_pop(cpu_pop), .serial_pop(serial_pop), .geo_pop(geo_pop),
   .cpu_rdy(cpu_rdy), .serial_rdy(serial_rdy), .geo_rdy_a(geo_rdy_a), .geo_rdy_b(geo_rdy_b)
);

// ==== test/ram_access_tb.sv ====
`timescale 1ns/10ps

module ram_access_tb;

   typedef enum logic [1:0] {P_CPU, P_SER, P_GEO, P_NONE} port_e;
   typedef enum logic [2:0] {OP_RD, OP_WR, OP_RDA, OP_RDB, OP_FULL} op_e;

   typedef struct packed {
      port_e                          port;
      op_e                            op;
      logic [gpu_ram_pkg::ADDR_W-1:0] addr;
      logic [15:0]                    data;  // byte ports use [7:0], OP_FULL uses bit 0
      logic [7:0]                     gap;   // cycles to the next step, 0 shares the cycle
      logic                           jit;   // add 0..3 random cycles to gap
   } step_t;

   logic                           clk, rst_n;
   logic                           cpu_rd, cpu_wr, serial_rd, serial_wr;
   logic                           geo_rd_a, geo_rd_b, geo_wr;
   logic [gpu_ram_pkg::ADDR_W-1:0] cpu_addr, serial_addr, geo_addr;
   logic [7:0]                     cpu_wdata, serial_wdata, cpu_data, serial_data;
   logic [15:0]                    geo_wdata, geo_data;
   logic                           cpu_rdy, serial_rdy, geo_rdy_a, geo_rdy_b, geo_full;

   step_t       tbl[$];
   logic [7:0]  ref_mem [2*gpu_ram_pkg::RAM_WORDS];  // byte view, aliases like the ram
   logic [7:0]  cpu_q[$], ser_q[$];                   // expected byte reads per port
   logic [15:0] geoa_q[$], geob_q[$];
   port_e       order_q[$];                           // byte reads in expected grant order
   port_e       last_byte = P_CPU;                    // cpu counts as last granted out of reset
   logic [31:0] rng = 32'd18;
   int          cycle_cnt = 0;
   int          limit = 0;
   int          lat_start = 0;                        // strobe edge of the timed cpu read
   int          val_errors = 0;
   int          other_errors = 0;
   bit          lat_used = 1'b0;
   bit          lat_armed = 1'b0;

   tb_clock_gen #(.PERIOD_NS(100), .RST_CYCLES(4)) tb_clock_gen_i (.clk(clk), .rst_n(rst_n));

   ram_access_top ram_access_top_i (.*);

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic check_value(input string what, input logic [15:0] got,
                              input logic [15:0] exp);
      if (got !== exp) begin
         val_errors++;
         $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic add_step(input port_e p, input op_e o, input int a, input int d,
                           input int g, input bit j);
      tbl.push_back('{p, o, a[gpu_ram_pkg::ADDR_W-1:0], d[15:0], g[7:0], j});
   endtask

   task automatic build_table();
      add_step(P_CPU, OP_WR,   'h00010, 'hA5,   0, 0);  // tie after reset, serial goes first
      add_step(P_SER, OP_WR,   'h00010, 'h3C,   4, 0);
      add_step(P_CPU, OP_RD,   'h00010, 0,      6, 0);  // timed read, keeps cpu byte
      add_step(P_CPU, OP_WR,   'h00100, 'h11,   2, 1);  // low lane
      add_step(P_SER, OP_WR,   'h00101, 'h22,   3, 1);  // high lane
      add_step(P_SER, OP_RD,   'h00100, 0,      3, 1);
      add_step(P_CPU, OP_RD,   'h00101, 0,      3, 1);
      add_step(P_GEO, OP_RDA,  'h00100, 0,      4, 1);  // both lanes at once
      add_step(P_CPU, OP_WR,   'h12345, 'h5A,   3, 0);  // above 8 KiB
      add_step(P_SER, OP_RD,   'h00345, 0,      4, 1);  // same byte after wrap
      add_step(P_GEO, OP_WR,   'h00200, 'hBEEF, 3, 0);
      add_step(P_CPU, OP_RD,   'h00200, 0,      3, 1);
      add_step(P_SER, OP_RD,   'h00201, 0,      3, 1);
      add_step(P_GEO, OP_RDB,  'h00201, 0,      3, 1);  // bit 0 ignored on wide reads
      add_step(P_GEO, OP_RDA,  'h00200, 0,      4, 1);
      add_step(P_CPU, OP_RD,   'h00100, 0,      0, 0);  // read tie, serial was last
      add_step(P_SER, OP_RD,   'h00101, 0,      4, 1);
      add_step(P_CPU, OP_RD,   'h00010, 0,      4, 1);
      add_step(P_CPU, OP_RD,   'h00201, 0,      0, 0);  // read tie, cpu was last
      add_step(P_SER, OP_RD,   'h00200, 0,      4, 1);
      add_step(P_NONE, OP_FULL, 0,      0,      1, 0);
      add_step(P_CPU, OP_WR,   'h00300, 'h01,   0, 0);  // cpu busy every cycle
      add_step(P_GEO, OP_WR,   'h00400, 'h1111, 1, 0);
      add_step(P_CPU, OP_WR,   'h00301, 'h02,   0, 0);
      add_step(P_GEO, OP_WR,   'h00402, 'h2222, 1, 0);
      add_step(P_CPU, OP_WR,   'h00302, 'h03,   0, 0);
      add_step(P_GEO, OP_WR,   'h00404, 'h3333, 1, 0);
      add_step(P_NONE, OP_FULL, 0,      1,      8, 0);  // three stuck behind byte traffic
      add_step(P_NONE, OP_FULL, 0,      0,      2, 0);  // drained
      add_step(P_GEO, OP_RDA,  'h00400, 0,      2, 0);
      add_step(P_GEO, OP_RDB,  'h00402, 0,      2, 0);
      add_step(P_GEO, OP_RDA,  'h00404, 0,      2, 0);
      add_step(P_SER, OP_RD,   'h00302, 0,      3, 1);
      add_step(P_CPU, OP_RD,   'h00300, 0,      4, 1);
   endtask

   task automatic clear_strobes();
      cpu_rd    = 1'b0;
      cpu_wr    = 1'b0;
      serial_rd = 1'b0;
      serial_wr = 1'b0;
      geo_rd_a  = 1'b0;
      geo_rd_b  = 1'b0;
      geo_wr    = 1'b0;
   endtask

   task automatic drive_step(input step_t s);
      case (s.port)
         P_CPU: begin
            cpu_rd    = (s.op == OP_RD);
            cpu_wr    = (s.op == OP_WR);
            cpu_addr  = s.addr;
            cpu_wdata = s.data[7:0];
         end
         P_SER: begin
            serial_rd    = (s.op == OP_RD);
            serial_wr    = (s.op == OP_WR);
            serial_addr  = s.addr;
            serial_wdata = s.data[7:0];
         end
         P_GEO: begin
            geo_rd_a  = (s.op == OP_RDA);
            geo_rd_b  = (s.op == OP_RDB);
            geo_wr    = (s.op == OP_WR);
            geo_addr  = s.addr;
            geo_wdata = s.data;
         end
         default: ;                   // flag checks drive nothing
      endcase
   endtask

   // updates the reference memory and queues the expected read data
   task automatic book_step(input step_t s);
      int b;
      b = int'(s.addr[gpu_ram_pkg::WORD_AW:0]);
      case (s.op)
         OP_WR: begin
            if (s.port == P_GEO) begin
               ref_mem[b & ~1] = s.data[7:0];   // even byte is the low lane
               ref_mem[b | 1]  = s.data[15:8];
            end else begin
               ref_mem[b] = s.data[7:0];
               last_byte  = s.port;
            end
         end
         OP_RD: begin
            if (s.port == P_CPU) begin
               cpu_q.push_back(ref_mem[b]);
               if (!lat_used) begin
                  lat_used  = 1'b1;
                  lat_armed = 1'b1;
                  lat_start = cycle_cnt + 1;    // next rising edge takes the strobe
               end
            end else begin
               ser_q.push_back(ref_mem[b]);
            end
            order_q.push_back(s.port);
            last_byte = s.port;
         end
         OP_RDA:  geoa_q.push_back({ref_mem[b | 1], ref_mem[b & ~1]});
         OP_RDB:  geob_q.push_back({ref_mem[b | 1], ref_mem[b & ~1]});
         default: check_value("geo_full", {15'd0, geo_full}, s.data);
      endcase
   endtask

   // one cycle worth of steps, byte ports booked in the order they get granted
   task automatic run_group(input int first, input int last);
      int cpu_idx;
      int ser_idx;
      cpu_idx = -1;
      ser_idx = -1;
      for (int k = first; k <= last; k++) begin
         drive_step(tbl[k]);
         if (tbl[k].port == P_CPU) begin
            cpu_idx = k;
         end else if (tbl[k].port == P_SER) begin
            ser_idx = k;
         end else begin
            book_step(tbl[k]);
         end
      end
      if (cpu_idx >= 0 && ser_idx >= 0 && last_byte == P_CPU) begin
         book_step(tbl[ser_idx]);      // tie goes to the port not granted last
         book_step(tbl[cpu_idx]);
      end else begin
         if (cpu_idx >= 0) book_step(tbl[cpu_idx]);
         if (ser_idx >= 0) book_step(tbl[ser_idx]);
      end
   endtask

   task automatic take_byte(input port_e p, input logic [7:0] data);
      logic [7:0] exp;
      if ((p == P_CPU && cpu_q.size() == 0) || (p == P_SER && ser_q.size() == 0)) begin
         other_errors++;
         $display("unexpected ready pulse on the %s port at %0t", p.name(), $time);
      end else begin
         exp = (p == P_CPU) ? cpu_q.pop_front() : ser_q.pop_front();
         check_value({p.name(), " read data"}, {8'd0, data}, {8'd0, exp});
         check_value("byte read order", 16'(p), 16'(order_q.pop_front()));
         if (p == P_CPU && lat_armed) begin
            lat_armed = 1'b0;
            check_value("cpu read latency", 16'(cycle_cnt - lat_start),
                        16'(1 + gpu_ram_pkg::READ_LATENCY));
         end
      end
   endtask

   task automatic take_word(input bit chan_b, input logic [15:0] data);
      if ((chan_b ? geob_q.size() : geoa_q.size()) == 0) begin
         other_errors++;
         $display("unexpected geometry ready pulse on channel %s at %0t",
                  chan_b ? "b" : "a", $time);
      end else if (chan_b) begin
         check_value("geo b read data", data, geob_q.pop_front());
      end else begin
         check_value("geo a read data", data, geoa_q.pop_front());
      end
   endtask

   // monitors, sampled mid cycle
   always @(negedge clk) begin
      if (rst_n) begin
         if (cpu_rdy)    take_byte(P_CPU, cpu_data);
         if (serial_rdy) take_byte(P_SER, serial_data);
         if (geo_rdy_a)  take_word(1'b0, geo_data);
         if (geo_rdy_b)  take_word(1'b1, geo_data);
      end
   end

   always @(posedge clk) begin
      cycle_cnt++;
      if (limit > 0 && cycle_cnt >= limit) begin
         $display("timeout after %0d cycles, reads still outstanding", cycle_cnt);
         $display("Something failed");
         $finish;
      end
   end

   initial begin
      int i;
      int last;
      int gap;
      int asrt_errors;
      clear_strobes();
      cpu_addr     = '0;
      cpu_wdata    = '0;
      serial_addr  = '0;
      serial_wdata = '0;
      geo_addr     = '0;
      geo_wdata    = '0;
      build_table();
      limit = tbl.size() * 20 + 200;
      @(posedge rst_n);
      @(negedge clk);
      check_value("ready lines and geo_full after reset",
                  {11'd0, cpu_rdy, serial_rdy, geo_rdy_a, geo_rdy_b, geo_full}, 16'd0);
      i = 0;
      while (i < tbl.size()) begin
         last = i;
         while (tbl[last].gap == 0 && last + 1 < tbl.size()) last++;   // same-cycle steps
         run_group(i, last);
         gap = tbl[last].gap;
         if (tbl[last].jit) begin
            rng = xorshift32(rng);
            gap += int'(rng % 4);
         end
         @(negedge clk);
         clear_strobes();             // strobes last one cycle
         repeat (gap - 1) @(negedge clk);
         i = last + 1;
      end
      while (cpu_q.size() + ser_q.size() + geoa_q.size() + geob_q.size() != 0) begin
         @(negedge clk);
      end
      repeat (10) @(negedge clk);    // room for stray pulses
      asrt_errors = ram_access_top_i.ram_access_properties_i.assert_errors;
      $display("errors: value %0d, other %0d, assertion %0d",
               val_errors, other_errors, asrt_errors);
      if (val_errors + other_errors + asrt_errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen #(
   parameter int PERIOD_NS  = 100,    // full clock period
   parameter int RST_CYCLES = 4       // rising edges seen with rst_n low
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   initial begin
      rst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;                   // release away from the active edge
   end

endmodule
